// File: memPkg.sv
`default_nettype none

package memPkg;

    // ram data byte and cpu word
    localparam int ByteWidth = 8;
    localparam int WordWidth = 32;
    localparam int MaxBytes  = 4;

    typedef logic [ByteWidth-1:0] byte_t;
    typedef logic [WordWidth-1:0] word_t;

    // access length in bytes, 1 to 4
    typedef logic [2:0] len_t;

    // byte lane inside a word
    typedef logic [1:0] byteIdx_t;

    // who owns the controller right now
    typedef enum logic [1:0] {
        ClientIdle,
        ClientFetch,
        ClientLoad,
        ClientStore
    } client_t;

endpackage

`default_nettype wire

// File: memRequestArbiter.sv
`default_nettype none

module memRequestArbiter #(
    parameter int AddrWidth = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_step,

    input  wire                   i_fetchEn,
    input  wire [AddrWidth-1:0]   i_fetchAddr,

    input  wire                   i_dataEn,
    input  wire                   i_dataIsStore,
    input  wire memPkg::len_t     i_dataLen,
    input  wire [AddrWidth-1:0]   i_dataAddr,
    input  wire memPkg::word_t    i_dataWr,

    input  wire                   i_finish,

    output memPkg::client_t       o_client,
    output logic [AddrWidth-1:0]  o_baseAddr,
    output memPkg::len_t          o_reqLen,
    output memPkg::word_t         o_storeWord
);

    memPkg::client_t state;
    logic            blockAccept;
    logic            accept;
    logic            goIdle;

    // a new request is taken only when idle and not frozen
    assign accept = i_step && (state == memPkg::ClientIdle) && !blockAccept &&
                    (i_dataEn || i_fetchEn);

    assign goIdle = i_step && i_finish && (state != memPkg::ClientIdle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= memPkg::ClientIdle;
            blockAccept <= 1'b0;
        end else begin
            // client still holds its enable during the done cycle
            blockAccept <= goIdle;
            if (accept) begin
                if (i_dataEn) begin
                    state <= i_dataIsStore ? memPkg::ClientStore : memPkg::ClientLoad;
                end else begin
                    state <= memPkg::ClientFetch;
                end
            end else if (goIdle) begin
                state <= memPkg::ClientIdle;
            end
        end
    end

    // data wins over fetch for the request fields
    always_ff @(posedge clk) begin
        if (accept) begin
            if (i_dataEn) begin
                o_baseAddr  <= i_dataAddr;
                o_reqLen    <= i_dataLen;
                o_storeWord <= i_dataWr;
            end else begin
                o_baseAddr  <= i_fetchAddr;
                o_reqLen    <= memPkg::len_t'(memPkg::MaxBytes);
            end
        end
    end

    assign o_client = state;

endmodule

`default_nettype wire

// File: memByteSequencer.sv
`default_nettype none

module memByteSequencer #(
    parameter int AddrWidth = 32
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_rdy,
    input  wire                       i_ioBufferFull,

    input  wire memPkg::client_t      i_client,
    input  wire [AddrWidth-1:0]       i_baseAddr,
    input  wire memPkg::len_t         i_reqLen,
    input  wire memPkg::word_t        i_storeWord,

    output logic                      o_step,

    output logic [AddrWidth-1:0]      o_memAddr,
    output logic                      o_memWrite,
    output memPkg::byte_t             o_memWrByte,

    output logic                      o_rdTagValid,
    output memPkg::byteIdx_t          o_rdTagIdx,
    output logic                      o_storeFinish
);

    logic             active;
    logic             reading;
    logic             storing;
    memPkg::byteIdx_t lastIdx;
    memPkg::byteIdx_t issueCnt;

    // the only place that looks at the freeze inputs
    assign o_step = i_rdy && !i_ioBufferFull;

    assign active  = (i_client != memPkg::ClientIdle);
    assign reading = (i_client == memPkg::ClientFetch) || (i_client == memPkg::ClientLoad);
    assign storing = (i_client == memPkg::ClientStore);

    assign lastIdx = memPkg::byteIdx_t'(i_reqLen - 3'd1);

    // byte issue counter that parks on the last byte of a read
    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt <= '0;
        end else if (!active) begin
            issueCnt <= '0;
        end else if (o_step && (issueCnt != lastIdx)) begin
            issueCnt <= issueCnt + 2'd1;
        end
    end

    // little endian with byte k at base+k
    assign o_memAddr = active ? (i_baseAddr + AddrWidth'(issueCnt)) : '0;

    assign o_memWrite    = storing && o_step;
    assign o_memWrByte   = i_storeWord[issueCnt*memPkg::ByteWidth +: memPkg::ByteWidth];
    assign o_storeFinish = storing && (issueCnt == lastIdx);

    // ram answers one cycle after the address so the tag trails by one
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rdTagValid <= 1'b0;
        end else begin
            o_rdTagValid <= reading;
        end
    end

    always_ff @(posedge clk) begin
        o_rdTagIdx <= issueCnt;
    end

endmodule

`default_nettype wire

// File: memResponseAssembler.sv
`default_nettype none

module memResponseAssembler (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_step,

    input  wire memPkg::client_t      i_client,
    input  wire memPkg::len_t         i_reqLen,

    input  wire                       i_rdTagValid,
    input  wire memPkg::byteIdx_t     i_rdTagIdx,
    input  wire memPkg::byte_t        i_memRdByte,

    output logic                      o_readFinish,

    output logic                      o_fetchDone,
    output memPkg::word_t             o_fetchInst,

    output logic                      o_dataDone,
    output memPkg::word_t             o_dataRd
);

    logic             reading;
    memPkg::byteIdx_t lastIdx;
    memPkg::word_t    word;
    memPkg::client_t  lastClient;

    assign reading = (i_client == memPkg::ClientFetch) || (i_client == memPkg::ClientLoad);

    assign lastIdx = memPkg::byteIdx_t'(i_reqLen - 3'd1);

    // cleared while idle so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (i_client == memPkg::ClientIdle) begin
            word <= '0;
        end else if (reading && i_rdTagValid) begin
            word[i_rdTagIdx*memPkg::ByteWidth +: memPkg::ByteWidth] <= i_memRdByte;
        end
    end

    assign o_readFinish = i_step && reading && i_rdTagValid && (i_rdTagIdx == lastIdx);

    // owner of the previous cycle for the done pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            lastClient <= memPkg::ClientIdle;
        end else begin
            lastClient <= i_client;
        end
    end

    // arbiter leaves a client only on finish so this is one cycle wide
    assign o_fetchDone = (i_client == memPkg::ClientIdle) &&
                         (lastClient == memPkg::ClientFetch);

    assign o_dataDone = (i_client == memPkg::ClientIdle) &&
                        ((lastClient == memPkg::ClientLoad) ||
                         (lastClient == memPkg::ClientStore));

    assign o_fetchInst = word;
    assign o_dataRd    = word;

endmodule

`default_nettype wire

// File: memController.sv
`default_nettype none

module memController #(
    parameter int AddrWidth = 32
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_rdy,
    input  wire                       i_ioBufferFull,

    // instruction fetch
    input  wire                       i_fetchEn,
    input  wire [AddrWidth-1:0]       i_fetchAddr,
    output logic                      o_fetchDone,
    output memPkg::word_t             o_fetchInst,

    // data load and store
    input  wire                       i_dataEn,
    input  wire                       i_dataIsStore,
    input  wire memPkg::len_t         i_dataLen,
    input  wire [AddrWidth-1:0]       i_dataAddr,
    input  wire memPkg::word_t        i_dataWr,
    output logic                      o_dataDone,
    output memPkg::word_t             o_dataRd,

    // byte ram
    input  wire memPkg::byte_t        i_memRdByte,
    output logic [AddrWidth-1:0]      o_memAddr,
    output logic                      o_memWrite,
    output memPkg::byte_t             o_memWrByte
);

    logic                  step;
    logic                  finish;
    logic                  storeFinish;
    logic                  readFinish;
    memPkg::client_t       client;
    logic [AddrWidth-1:0]  baseAddr;
    memPkg::len_t          reqLen;
    memPkg::word_t         storeWord;
    logic                  rdTagValid;
    memPkg::byteIdx_t      rdTagIdx;

    assign finish = storeFinish | readFinish;

    memRequestArbiter #(
        .AddrWidth (AddrWidth)
    ) u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_step        (step),
        .i_fetchEn     (i_fetchEn),
        .i_fetchAddr   (i_fetchAddr),
        .i_dataEn      (i_dataEn),
        .i_dataIsStore (i_dataIsStore),
        .i_dataLen     (i_dataLen),
        .i_dataAddr    (i_dataAddr),
        .i_dataWr      (i_dataWr),
        .i_finish      (finish),
        .o_client      (client),
        .o_baseAddr    (baseAddr),
        .o_reqLen      (reqLen),
        .o_storeWord   (storeWord)
    );

    memByteSequencer #(
        .AddrWidth (AddrWidth)
    ) u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_client       (client),
        .i_baseAddr     (baseAddr),
        .i_reqLen       (reqLen),
        .i_storeWord    (storeWord),
        .o_step         (step),
        .o_memAddr      (o_memAddr),
        .o_memWrite     (o_memWrite),
        .o_memWrByte    (o_memWrByte),
        .o_rdTagValid   (rdTagValid),
        .o_rdTagIdx     (rdTagIdx),
        .o_storeFinish  (storeFinish)
    );

    memResponseAssembler u_assembler (
        .clk          (clk),
        .rst          (rst),
        .i_step       (step),
        .i_client     (client),
        .i_reqLen     (reqLen),
        .i_rdTagValid (rdTagValid),
        .i_rdTagIdx   (rdTagIdx),
        .i_memRdByte  (i_memRdByte),
        .o_readFinish (readFinish),
        .o_fetchDone  (o_fetchDone),
        .o_fetchInst  (o_fetchInst),
        .o_dataDone   (o_dataDone),
        .o_dataRd     (o_dataRd)
    );

endmodule

`default_nettype wire

// File: tbRamModel.sv
`default_nettype none

module tbRamModel #(
    parameter int AddrBits = 16
) (
    input  wire                  clk,
    input  wire [AddrBits-1:0]   i_addr,
    input  wire                  i_write,
    input  wire memPkg::byte_t   i_wrByte,
    output memPkg::byte_t        o_rdByte
);

    timeunit 1ns;
    timeprecision 1ps;

    memPkg::byte_t mem [0:(1<<AddrBits)-1];

    // every byte mixes both halves of its address
    initial begin
        o_rdByte = '0;
        for (int a = 0; a < (1 << AddrBits); a++) begin
            mem[a] = memPkg::byte_t'(a[7:0] ^ (a[15:8] * 8'd29) ^ 8'h6b);
        end
    end

    // one cycle of read latency and read before write
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr] <= i_wrByte;
        end
        o_rdByte <= mem[i_addr];
    end

endmodule

`default_nettype wire

// File: tb_memController.sv
`default_nettype none

module tb_memController;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RamAddrBits     = 16;
    localparam int NumRandom       = 40;
    localparam int NumTransactions = 15 + 2 * NumRandom;
    localparam int CycleLimit      = NumTransactions * 20 + 100;
    localparam logic [31:0] Seed   = 32'h36be6021;

    typedef struct packed {
        memPkg::word_t value;
        logic          isStore;
        logic          checkLat;
        logic [31:0]   latency;
        logic [31:0]   start;
    } expect_t;

    logic                    clk          = 1'b0;
    logic                    rst          = 1'b1;
    logic                    rdy          = 1'b1;
    logic                    ioBufferFull = 1'b0;
    logic                    fetchEn      = 1'b0;
    logic [RamAddrBits-1:0]  fetchAddr    = '0;
    logic                    dataEn       = 1'b0;
    logic                    dataIsStore  = 1'b0;
    memPkg::len_t            dataLen      = 3'd4;
    logic [RamAddrBits-1:0]  dataAddr     = '0;
    memPkg::word_t           dataWr       = '0;
    memPkg::byte_t           memRdByte;

    logic                    fetchDone;
    memPkg::word_t           fetchInst;
    logic                    dataDone;
    memPkg::word_t           dataRd;
    logic [RamAddrBits-1:0]  memAddr;
    logic                    memWrite;
    memPkg::byte_t           memWrByte;

    logic                    stallOn    = 1'b0;
    logic [31:0]             stimState  = Seed;
    logic [31:0]             stallState = ~Seed;
    logic [31:0]             cycleCnt   = '0;
    memPkg::byte_t           shadow [0:(1<<RamAddrBits)-1];
    expect_t                 dataExp[$];
    expect_t                 fetchExp[$];

    always #50 clk = ~clk;

    memController #(
        .AddrWidth (RamAddrBits)
    ) u_memController (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .i_dataEn       (dataEn),
        .i_dataIsStore  (dataIsStore),
        .i_dataLen      (dataLen),
        .i_dataAddr     (dataAddr),
        .i_dataWr       (dataWr),
        .o_dataDone     (dataDone),
        .o_dataRd       (dataRd),
        .i_memRdByte    (memRdByte),
        .o_memAddr      (memAddr),
        .o_memWrite     (memWrite),
        .o_memWrByte    (memWrByte)
    );

    tbRamModel #(
        .AddrBits (RamAddrBits)
    ) u_ram (
        .clk      (clk),
        .i_addr   (memAddr),
        .i_write  (memWrite),
        .i_wrByte (memWrByte),
        .o_rdByte (memRdByte)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic memPkg::byte_t fillByte(input int a);
        return memPkg::byte_t'(a[7:0] ^ (a[15:8] * 8'd29) ^ 8'h6b);
    endfunction

    // little endian bytes from the shadow with zero extension
    function automatic memPkg::word_t expectedRead(input logic [RamAddrBits-1:0] addr,
                                                   input memPkg::len_t len);
        memPkg::word_t value;
        value = '0;
        for (int k = 0; k < int'(len); k++) begin
            value[8*k +: 8] = shadow[addr + RamAddrBits'(k)];
        end
        return value;
    endfunction

    task automatic abortRun();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic startData(input logic isStore, input memPkg::len_t len,
                             input logic [RamAddrBits-1:0] addr, input memPkg::word_t wr,
                             input logic checkLat);
        expect_t e;
        e.isStore  = isStore;
        e.value    = isStore ? '0 : expectedRead(addr, len);
        e.checkLat = checkLat;
        e.latency  = isStore ? 32'(len) + 32'd2 : 32'(len) + 32'd3;
        e.start    = cycleCnt;
        if (isStore) begin
            for (int k = 0; k < int'(len); k++) begin
                shadow[addr + RamAddrBits'(k)] = wr[8*k +: 8];
            end
        end
        dataExp.push_back(e);
        dataEn      <= 1'b1;
        dataIsStore <= isStore;
        dataLen     <= len;
        dataAddr    <= addr;
        dataWr      <= wr;
    endtask

    task automatic startFetch(input logic [RamAddrBits-1:0] addr, input logic checkLat);
        expect_t e;
        e.isStore  = 1'b0;
        e.value    = expectedRead(addr, 3'd4);
        e.checkLat = checkLat;
        e.latency  = 32'd7;
        e.start    = cycleCnt;
        fetchExp.push_back(e);
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
    endtask

    // client drops its enable on the edge that shows done
    task automatic waitData();
        @(posedge clk);
        while (!dataDone) begin
            @(posedge clk);
        end
        dataEn <= 1'b0;
    endtask

    task automatic waitFetch();
        @(posedge clk);
        while (!fetchDone) begin
            @(posedge clk);
        end
        fetchEn <= 1'b0;
    endtask

    task automatic runData(input logic isStore, input memPkg::len_t len,
                           input logic [RamAddrBits-1:0] addr, input memPkg::word_t wr,
                           input logic checkLat);
        startData(isStore, len, addr, wr, checkLat);
        waitData();
        @(posedge clk);
    endtask

    task automatic runFetch(input logic [RamAddrBits-1:0] addr, input logic checkLat);
        startFetch(addr, checkLat);
        waitFetch();
        @(posedge clk);
    endtask

    // both enables rise together and data must win
    task automatic runDataAndFetch(input logic isStore, input memPkg::len_t len,
                                   input logic [RamAddrBits-1:0] addr, input memPkg::word_t wr,
                                   input logic [RamAddrBits-1:0] instAddr);
        startData(isStore, len, addr, wr, 1'b0);
        startFetch(instAddr, 1'b0);
        waitData();
        waitFetch();
        @(posedge clk);
    endtask

    // rdy low about 1 in 4 and buffer full about 1 in 8
    always @(posedge clk) begin
        if (stallOn) begin
            stallState = lcgNext(stallState);
            rdy          <= (stallState[31:30] != 2'b00);
            ioBufferFull <= (stallState[29:27] == 3'b000);
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 32'd1;
        if (cycleCnt == CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            abortRun();
        end
    end

    // compare every done pulse against the queued expectation
    always @(posedge clk) begin
        expect_t e;
        if (!rst) begin
            if (dataExp.size() == 0 && fetchExp.size() == 0) begin
                assert (!memWrite && !dataDone && !fetchDone && memAddr == '0) else begin
                    $display("controller was active with no request pending at %0t", $time);
                    abortRun();
                end
            end
            if (memWrite) begin
                assert (rdy && !ioBufferFull) else begin
                    $display("write strobe was raised in a frozen cycle at %0t", $time);
                    abortRun();
                end
            end
            if (dataDone) begin
                assert (dataExp.size() != 0) else begin
                    $display("data done pulse came with no data request pending");
                    abortRun();
                end
                e = dataExp.pop_front();
                assert (e.isStore || dataRd == e.value) else begin
                    $display("error at %0t: load returned 0x%08h, expected 0x%08h",
                             $time, dataRd, e.value);
                    abortRun();
                end
                assert (!e.checkLat || cycleCnt - e.start == e.latency) else begin
                    $display("error at %0t: data done after %0d edges, expected %0d",
                             $time, cycleCnt - e.start, e.latency);
                    abortRun();
                end
            end
            if (fetchDone) begin
                assert (fetchExp.size() != 0 && dataExp.size() == 0) else begin
                    $display("fetch done pulse came unrequested or ahead of a data request");
                    abortRun();
                end
                e = fetchExp.pop_front();
                assert (fetchInst == e.value) else begin
                    $display("error at %0t: fetch returned 0x%08h, expected 0x%08h",
                             $time, fetchInst, e.value);
                    abortRun();
                end
                assert (!e.checkLat || cycleCnt - e.start == e.latency) else begin
                    $display("error at %0t: fetch done after %0d edges, expected %0d",
                             $time, cycleCnt - e.start, e.latency);
                    abortRun();
                end
            end
        end
    end

    initial begin
        memPkg::len_t            len;
        logic [1:0]              op;
        logic [RamAddrBits-1:0]  addr;
        logic [RamAddrBits-1:0]  instAddr;
        memPkg::word_t           wr;
        for (int a = 0; a < (1 << RamAddrBits); a++) begin
            shadow[a] = fillByte(a);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // no stalls so latency is exact
        runFetch(16'h0100, 1'b1);
        runFetch(16'h7ffe, 1'b1);
        runFetch(16'hfffc, 1'b1);
        runData(1'b0, 3'd1, 16'h0203, '0, 1'b1);
        runData(1'b0, 3'd2, 16'h1235, '0, 1'b1);
        runData(1'b0, 3'd4, 16'h4001, '0, 1'b1);
        runData(1'b1, 3'd1, 16'h0203, 32'h5a5a5aa5, 1'b1);
        runData(1'b1, 3'd2, 16'h1236, 32'h1111beef, 1'b1);
        runData(1'b1, 3'd4, 16'h4001, 32'hcafe1234, 1'b1);
        runData(1'b0, 3'd4, 16'h0200, '0, 1'b1);
        runData(1'b0, 3'd4, 16'h1234, '0, 1'b1);
        runData(1'b0, 3'd4, 16'h4000, '0, 1'b1);
        runData(1'b0, 3'd4, 16'h4004, '0, 1'b1);
        runDataAndFetch(1'b1, 3'd4, 16'h0300, 32'h0badf00d, 16'h0302);

        // random mix under freeze
        stallOn <= 1'b1;
        for (int i = 0; i < NumRandom; i++) begin
            stimState = lcgNext(stimState);
            op = stimState[31:30];
            case (stimState[29:28])
                2'd0:    len = 3'd1;
                2'd1:    len = 3'd2;
                default: len = 3'd4;
            endcase
            stimState = lcgNext(stimState);
            addr = stimState[31:16];
            stimState = lcgNext(stimState);
            wr = stimState;
            stimState = lcgNext(stimState);
            instAddr = stimState[31:16];
            case (op)
                2'd0:    runFetch(instAddr, 1'b0);
                2'd1:    runData(1'b0, len, addr, '0, 1'b0);
                2'd2:    runData(1'b1, len, addr, wr, 1'b0);
                default: runDataAndFetch(wr[0], len, addr, wr, instAddr);
            endcase
        end

        @(posedge clk);
        if (dataExp.size() == 0 && fetchExp.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("some requests never got a done pulse");
            abortRun();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
memPkg.sv
memRequestArbiter.sv
memByteSequencer.sv
memResponseAssembler.sv
memController.sv
tbRamModel.sv
tb_memController.sv

// File: Makefile
# Verilator build, run, lint and clean for the memory controller

VERILATOR  ?= verilator
TOP        ?= tb_memController
LINT_TOP   ?= memController
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
